// File: hw/soc_event_pkg.sv
package soc_event_pkg;

    ////////////////////
    // Event path
    ////////////////////

    localparam int unsigned EVNT_WIDTH = 8;
    typedef logic [EVNT_WIDTH-1:0] event_id_t;

    // Advanced timer, GPIO and HWPE lines
    localparam int unsigned NUM_EVT_LINES = 7;
    typedef logic [NUM_EVT_LINES-1:0] evt_vec_t;

    // Line k carries event number EVT_ID_BASE + k
    localparam int unsigned EVT_ID_BASE = 135;

    // First field is the MSB, so adv_timer lands on lines 0-3
    typedef struct packed {
        logic [1:0] hwpe;
        logic       gpio;
        logic [3:0] adv_timer;
    } periph_evt_t;

    ////////////////////
    // Interrupt vector
    ////////////////////

    typedef logic [31:0] irq_vec_t;

    // Bits 0-7 stay free for software events
    localparam int unsigned IRQ_DMA_PE_EVT = 8;
    localparam int unsigned IRQ_DMA_PE_IRQ = 9;
    localparam int unsigned IRQ_PF_EVT     = 12;

    // Both edges of the reference clock
    localparam int unsigned IRQ_REF_CLK = 14;
    localparam int unsigned IRQ_GPIO    = 15;

    // Four timer events on 17 to 20
    localparam int unsigned IRQ_ADV_TIMER_BASE = 17;

    // Lost event on the event path
    localparam int unsigned IRQ_EVT_ERR = 29;

endpackage

// File: hw/ref_edge_detect.sv
`timescale 1ns/1ps

module ref_edge_detect #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic serial_i,
    output logic edge_o
);

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   prev_q;
    logic                   edge_q;

    // Synchronizer chain, then one more sample for the comparison
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sync_q <= '0;
            prev_q <= 1'b0;
            edge_q <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], serial_i};
            prev_q <= sync_q[SYNC_STAGES-1];
            // Rising or falling edge, one pulse each
            edge_q <= sync_q[SYNC_STAGES-1] ^ prev_q;
        end
    end

    assign edge_o = edge_q;

endmodule

// File: hw/event_capture.sv
`timescale 1ns/1ps

module event_capture
    import soc_event_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    input  periph_evt_t evt_i,
    input  evt_vec_t    clear_i,
    output evt_vec_t    pending_o,
    output logic        err_o
);

    evt_vec_t evt_vec;
    evt_vec_t sample_q;
    evt_vec_t rise;
    evt_vec_t pending_q;
    evt_vec_t pending_d;
    logic     lost;
    logic     err_q;

    assign evt_vec = evt_i;

    // Rise against the previous sample
    assign rise = evt_vec & ~sample_q;

    // A rise overrides a clear on the same line
    assign pending_d = (pending_q & ~clear_i) | rise;

    // Line still pending and not leaving this cycle, so the new rise is dropped
    assign lost = |(rise & pending_q & ~clear_i);

    ////////////////////
    // State
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sample_q  <= '0;
            pending_q <= '0;
            err_q     <= 1'b0;
        end else begin
            sample_q  <= evt_vec;
            pending_q <= pending_d;
            err_q     <= lost;
        end
    end

    assign pending_o = pending_q;
    assign err_o     = err_q;

endmodule

// File: hw/event_arbiter.sv
`timescale 1ns/1ps

module event_arbiter
    import soc_event_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  evt_vec_t  pending_i,
    output evt_vec_t  clear_o,
    output event_id_t id_o,
    output logic      valid_o,
    input  logic      ready_i
);

    localparam int unsigned IDX_W = $clog2(NUM_EVT_LINES);

    logic [IDX_W-1:0] sel_idx;
    evt_vec_t         sel_onehot;
    logic             any_pending;
    logic             load;
    logic             valid_q;
    event_id_t        id_q;

    // Lowest set bit
    assign sel_onehot  = pending_i & (~pending_i + 1'b1);
    assign any_pending = |pending_i;

    // Scan from the top so the lowest pending line wins
    always_comb begin
        sel_idx = '0;
        for (int i = NUM_EVT_LINES - 1; i >= 0; i--) begin
            if (pending_i[i]) begin
                sel_idx = IDX_W'(i);
            end
        end
    end

    // Register is free, or its entry leaves this cycle
    assign load    = !valid_q || ready_i;
    assign clear_o = load ? sel_onehot : '0;

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= any_pending;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load && any_pending) begin
            id_q <= event_id_t'(EVT_ID_BASE) + event_id_t'(sel_idx);
        end
    end

    assign id_o    = id_q;
    assign valid_o = valid_q;

endmodule

// File: hw/event_fifo.sv
`timescale 1ns/1ps

module event_fifo
    import soc_event_pkg::*;
#(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  event_id_t push_id_i,
    input  logic      push_valid_i,
    output logic      push_ready_o,
    output event_id_t pop_id_o,
    output logic      pop_valid_o,
    input  logic      pop_ready_i
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

    event_id_t        mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign push_ready_o = (count_q != FULL_COUNT);
    assign pop_valid_o  = (count_q != '0);

    assign push = push_valid_i && push_ready_o;
    assign pop  = pop_valid_o && pop_ready_i;

    // Head entry is only overwritten after it has been popped
    assign pop_id_o = mem_q[rd_ptr_q];

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

endmodule

// File: hw/soc_event_unit.sv
`timescale 1ns/1ps

module soc_event_unit
    import soc_event_pkg::*;
#(
    parameter int unsigned SYNC_STAGES = 2,
    parameter int unsigned FIFO_DEPTH  = 4
) (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        slow_clk_i,
    input  periph_evt_t periph_evt_i,
    input  logic        dma_pe_evt_i,
    input  logic        dma_pe_irq_i,
    input  logic        pf_evt_i,
    output event_id_t   fc_event_o,
    output logic        fc_event_valid_o,
    input  logic        fc_event_ready_i,
    output irq_vec_t    fc_interrupts_o
);

    evt_vec_t  pending;
    evt_vec_t  clear;
    event_id_t arb_id;
    logic      arb_valid;
    logic      fifo_ready;
    logic      evt_err;
    logic      ref_edge;

    ////////////////////
    // Event path
    ////////////////////

    // Edges into pending bits
    event_capture i_event_capture (
        .clk_i     ( clk_i        ),
        .rst_ni    ( rst_ni       ),
        .evt_i     ( periph_evt_i ),
        .clear_i   ( clear        ),
        .pending_o ( pending      ),
        .err_o     ( evt_err      )
    );

    event_arbiter i_event_arbiter (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .pending_i ( pending    ),
        .clear_o   ( clear      ),
        .id_o      ( arb_id     ),
        .valid_o   ( arb_valid  ),
        .ready_i   ( fifo_ready )
    );

    // Queue toward the fabric controller
    event_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) i_event_fifo (
        .clk_i        ( clk_i            ),
        .rst_ni       ( rst_ni           ),
        .push_id_i    ( arb_id           ),
        .push_valid_i ( arb_valid        ),
        .push_ready_o ( fifo_ready       ),
        .pop_id_o     ( fc_event_o       ),
        .pop_valid_o  ( fc_event_valid_o ),
        .pop_ready_i  ( fc_event_ready_i )
    );

    ////////////////////
    // Reference clock
    ////////////////////

    ref_edge_detect #(
        .SYNC_STAGES ( SYNC_STAGES )
    ) i_ref_edge_detect (
        .clk_i    ( clk_i      ),
        .rst_ni   ( rst_ni     ),
        .serial_i ( slow_clk_i ),
        .edge_o   ( ref_edge   )
    );

    // Interrupt vector, unused positions tie to 0
    always_comb begin
        fc_interrupts_o = '0;
        fc_interrupts_o[IRQ_DMA_PE_EVT] = dma_pe_evt_i;
        fc_interrupts_o[IRQ_DMA_PE_IRQ] = dma_pe_irq_i;
        fc_interrupts_o[IRQ_PF_EVT]     = pf_evt_i;
        fc_interrupts_o[IRQ_REF_CLK]    = ref_edge;
        fc_interrupts_o[IRQ_GPIO]       = periph_evt_i.gpio;
        fc_interrupts_o[IRQ_ADV_TIMER_BASE +: 4] = periph_evt_i.adv_timer;
        fc_interrupts_o[IRQ_EVT_ERR]    = evt_err;
    end

endmodule

// File: testbench/soc_event_checker.sv
`timescale 1ns/1ps

module soc_event_checker
    import soc_event_pkg::*;
(
    input logic      clk_i,
    input logic      rst_ni,
    input event_id_t fc_event_o,
    input logic      fc_event_valid_o,
    input logic      fc_event_ready_i,
    input irq_vec_t  fc_interrupts_o
);

    // Bits 8, 9, 12, 14, 15, 17-20 and 29 carry interrupts
    localparam irq_vec_t USED_IRQ = 32'h201E_D300;

    int unsigned fail_cnt = 0;

    ////////////////////
    // Handshake
    ////////////////////

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fc_event_valid_o && !fc_event_ready_i |=> fc_event_valid_o && $stable(fc_event_o))
        else begin
            $error("event output changed while stalled");
            fail_cnt++;
        end

    assert property (@(posedge clk_i) !rst_ni |-> !fc_event_valid_o)
        else begin
            $error("event valid high during reset");
            fail_cnt++;
        end

    ////////////////////
    // Interrupt vector
    ////////////////////

    assert property (@(posedge clk_i) (fc_interrupts_o & ~USED_IRQ) == '0)
        else begin
            $error("reserved interrupt bit set");
            fail_cnt++;
        end

    // Lost-event error is a single-cycle pulse
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        fc_interrupts_o[IRQ_EVT_ERR] |=> !fc_interrupts_o[IRQ_EVT_ERR])
        else begin
            $error("event error interrupt held for two cycles");
            fail_cnt++;
        end

endmodule

bind soc_event_unit soc_event_checker soc_event_checker_inst (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .fc_event_o       ( fc_event_o       ),
    .fc_event_valid_o ( fc_event_valid_o ),
    .fc_event_ready_i ( fc_event_ready_i ),
    .fc_interrupts_o  ( fc_interrupts_o  )
);

// File: testbench/tb_soc_event_unit.sv
`timescale 1ns/1ps

module tb_soc_event_unit
    import soc_event_pkg::*;
();

    localparam int unsigned TIMEOUT  = 200;
    localparam int unsigned QUIET    = 20;
    localparam int unsigned N_REF    = 6;
    localparam int unsigned NUM_ROWS = 7;

    // One stimulus row
    // irq_in holds {pf_evt, dma_pe_irq, dma_pe_evt}
    typedef struct {
        string       name;
        logic [6:0]  mask;
        bit          hold_ready;
        logic [2:0]  irq_in;
        logic [31:0] exp_irq;
    } row_t;

    logic        clk_i;
    logic        rst_ni;
    logic        slow_clk;
    periph_evt_t periph_evt;
    logic        dma_pe_evt;
    logic        dma_pe_irq;
    logic        pf_evt;
    event_id_t   fc_event;
    logic        fc_event_valid;
    logic        fc_event_ready;
    irq_vec_t    fc_interrupts;

    row_t        rows [NUM_ROWS];
    event_id_t   got [$];
    int unsigned err_cnt       = 0;
    int unsigned ref_high_cnt  = 0;
    int unsigned ref_pulse_cnt = 0;
    logic        ref_prev      = 1'b0;

    soc_event_unit soc_event_unit_inst (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_ni         ),
        .slow_clk_i       ( slow_clk       ),
        .periph_evt_i     ( periph_evt     ),
        .dma_pe_evt_i     ( dma_pe_evt     ),
        .dma_pe_irq_i     ( dma_pe_irq     ),
        .pf_evt_i         ( pf_evt         ),
        .fc_event_o       ( fc_event       ),
        .fc_event_valid_o ( fc_event_valid ),
        .fc_event_ready_i ( fc_event_ready ),
        .fc_interrupts_o  ( fc_interrupts  )
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////
    // Output monitor
    ////////////////////

    // Samples the pre-edge values that the DUT acts on
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (fc_event_valid && fc_event_ready) begin
                got.push_back(fc_event);
            end
            if (fc_interrupts[29]) begin
                err_cnt++;
            end
            if (fc_interrupts[14]) begin
                ref_high_cnt++;
                if (!ref_prev) begin
                    ref_pulse_cnt++;
                end
            end
            ref_prev = fc_interrupts[14];
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    // Bound assertions count their failures in the checker
    always @(posedge clk_i) begin
        if (soc_event_unit_inst.soc_event_checker_inst.fail_cnt != 0) begin
            $display("ERROR: an assertion on the DUT outputs failed");
            abort_run();
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_valid(input string name);
        int unsigned cycles;
        cycles = 0;
        while (fc_event_valid !== 1'b1) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("ERROR: %s, no event became valid in time", name);
                abort_run();
            end
        end
    endtask

    task automatic wait_error(input int unsigned target, input string name);
        int unsigned cycles;
        cycles = 0;
        while (err_cnt < target) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("ERROR: %s, lost-event interrupt never pulsed", name);
                abort_run();
            end
        end
    endtask

    task automatic wait_events(input int unsigned n, input string name);
        int unsigned cycles;
        cycles = 0;
        while (got.size() < n) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("ERROR: %s, only %0d of %0d events arrived", name, got.size(), n);
                abort_run();
            end
        end
    endtask

    task automatic run_row(input row_t row);
        int unsigned n_exp;
        int unsigned pos;
        int unsigned err_base;
        n_exp    = 0;
        pos      = 0;
        err_base = err_cnt;
        got.delete();
        @(posedge clk_i);
        fc_event_ready <= !row.hold_ready;
        periph_evt     <= periph_evt_t'(row.mask);
        {pf_evt, dma_pe_irq, dma_pe_evt} <= row.irq_in;
        @(negedge clk_i);
        check_value({row.name, "_irq"}, row.exp_irq, fc_interrupts);
        @(posedge clk_i);
        periph_evt <= '0;
        if (row.hold_ready) begin
            wait_valid(row.name);
            check_value({row.name, "_no_err"}, err_base, err_cnt);
            // Line 6 rises again while it still waits behind the full FIFO
            @(posedge clk_i);
            periph_evt <= periph_evt_t'(7'b100_0000);
            @(posedge clk_i);
            periph_evt <= '0;
            wait_error(err_base + 1, row.name);
            @(posedge clk_i);
            fc_event_ready <= 1'b1;
        end
        for (int k = 0; k < 7; k++) begin
            if (row.mask[k]) begin
                n_exp++;
            end
        end
        wait_events(n_exp, row.name);
        repeat (QUIET) @(negedge clk_i);
        check_value({row.name, "_count"}, n_exp, got.size());
        // Line k carries event 135 + k and the lowest line comes first
        for (int k = 0; k < 7; k++) begin
            if (row.mask[k]) begin
                check_value($sformatf("%s_ev%0d", row.name, pos), 135 + k, got[pos]);
                pos++;
            end
        end
        check_value({row.name, "_err"}, err_base + row.hold_ready, err_cnt);
    endtask

    task automatic check_ref_clock();
        int unsigned cycles;
        cycles = 0;
        check_value("ref_idle", 0, ref_pulse_cnt);
        for (int t = 0; t < N_REF; t++) begin
            @(posedge clk_i);
            slow_clk <= ~slow_clk;
            repeat (10) @(posedge clk_i);
        end
        while (ref_pulse_cnt < N_REF) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("ERROR: reference clock edges missing, saw %0d", ref_pulse_cnt);
                abort_run();
            end
        end
        repeat (QUIET) @(negedge clk_i);
        check_value("ref_pulses", N_REF, ref_pulse_cnt);
        check_value("ref_high_cycles", N_REF, ref_high_cnt);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        rows[0] = '{"single_t0", 7'h01, 1'b0, 3'b000, 32'h0002_0000};
        rows[1] = '{"gpio_only", 7'h10, 1'b0, 3'b001, 32'h0000_8100};
        rows[2] = '{"hwpe_pair", 7'h60, 1'b0, 3'b010, 32'h0000_0200};
        rows[3] = '{"timer_mix", 7'h0A, 1'b0, 3'b100, 32'h0014_1000};
        rows[4] = '{"spread", 7'h55, 1'b0, 3'b111, 32'h000A_9300};
        rows[5] = '{"all_ready", 7'h7F, 1'b0, 3'b011, 32'h001E_8300};
        rows[6] = '{"all_held", 7'h7F, 1'b1, 3'b000, 32'h001E_8000};

        rst_ni         = 1'b1;
        slow_clk       = 1'b0;
        periph_evt     = '0;
        dma_pe_evt     = 1'b0;
        dma_pe_irq     = 1'b0;
        pf_evt         = 1'b0;
        fc_event_ready = 1'b1;
        #1 rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        check_value("reset_valid", 0, fc_event_valid);
        check_value("reset_irq", 0, fc_interrupts);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        check_ref_clock();

        if (soc_event_unit_inst.soc_event_checker_inst.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/soc_event_pkg.sv
hw/ref_edge_detect.sv
hw/event_capture.sv
hw/event_arbiter.sv
hw/event_fifo.sv
hw/soc_event_unit.sv
testbench/soc_event_checker.sv
testbench/tb_soc_event_unit.sv

// File: Bender.yml
package:
  name: soc_event_unit

sources:
  # RTL in compile order
  - files:
      - hw/soc_event_pkg.sv
      - hw/ref_edge_detect.sv
      - hw/event_capture.sv
      - hw/event_arbiter.sv
      - hw/event_fifo.sv
      - hw/soc_event_unit.sv

  # Testbench and bound assertions
  - target: test
    files:
      - testbench/soc_event_checker.sv
      - testbench/tb_soc_event_unit.sv
